// ==== all.f ====
design/color_proc_pkg.sv
design/frame_scanner.sv
design/filter_mode_select.sv
design/color_classifier.sv
design/histogram_counter.sv
design/color_proc_top.sv
sim/tb_color_proc.sv

// ==== design/color_classifier.sv ====
// purely combinational; ratio thresholds are fixed at two to one with a tolerance of one step
`timescale 1ns/1ps

module color_classifier
  import color_proc_pkg::*;
(
  input  pxl_t         orig_pxl_i,
  input  filter_mode_t filter_mode_i,
  output logic         pass_o,
  output pxl_t         proc_pxl_o
);

  chan_t red;
  chan_t grn;
  chan_t blu;

  // x_dom_y: channel x is roughly twice channel y or more
  logic red_dom_grn;
  logic red_dom_blu;
  logic grn_dom_red;
  logic grn_dom_blu;
  logic blu_dom_red;
  logic blu_dom_grn;

  // per-color decisions
  logic red_ok;
  logic grn_ok;
  logic blu_ok;
  logic yel_ok;
  logic mag_ok;
  logic cya_ok;
  logic whi_ok;

  // half of a, rounded down, against b minus one
  // b of zero wraps to 15, so nothing dominates a zero channel by accident
  function automatic logic dominates(input chan_t a, input chan_t b);
    chan_t half_a;
    chan_t b_dec;
    half_a = a >> 1;
    b_dec  = b - 1'b1;
    return half_a >= b_dec;
  endfunction

  // channel split, red in the high nibble
  assign red = orig_pxl_i[3*chan_bits-1:2*chan_bits];
  assign grn = orig_pxl_i[2*chan_bits-1:chan_bits];
  assign blu = orig_pxl_i[chan_bits-1:0];

  assign red_dom_grn = dominates(red, grn);
  assign red_dom_blu = dominates(red, blu);
  assign grn_dom_red = dominates(grn, red);
  assign grn_dom_blu = dominates(grn, blu);
  assign blu_dom_red = dominates(blu, red);
  assign blu_dom_grn = dominates(blu, grn);

  // primaries, one channel above both others
  assign red_ok = red_dom_grn && red_dom_blu;
  assign grn_ok = grn_dom_red && grn_dom_blu;
  assign blu_ok = blu_dom_red && blu_dom_grn;

  // secondaries, two channels over the third and close to each other
  assign yel_ok = red_dom_blu && grn_dom_blu && !red_dom_grn && !grn_dom_red;
  assign mag_ok = red_dom_grn && blu_dom_grn && !red_dom_blu && !blu_dom_red;
  assign cya_ok = grn_dom_red && blu_dom_red && !grn_dom_blu && !blu_dom_grn;

  // white, all balanced and not too dark
  // red level alone is taken as the brightness check
  assign whi_ok = !red_dom_grn && !grn_dom_red &&
                  !red_dom_blu && !blu_dom_red &&
                  !grn_dom_blu && !blu_dom_grn &&
                  (red > chan_t'(3));

  always_comb begin
    case (filter_mode_i)
      mode_red:     pass_o = red_ok;
      mode_green:   pass_o = grn_ok;
      mode_blue:    pass_o = blu_ok;
      mode_yellow:  pass_o = yel_ok;
      mode_magenta: pass_o = mag_ok;
      mode_cyan:    pass_o = cya_ok;
      mode_white:   pass_o = whi_ok;
      // no filter, everything passes
      default:      pass_o = 1'b1;
    endcase
  end

  // rejected pixels are blacked out in the processed image
  assign proc_pxl_o = pass_o ? orig_pxl_i : black_pxl;

endmodule

// ==== design/color_proc_pkg.sv ====
// fixed 160x120 rgb444 image geometry; widths below only hold for these sizes and 8 bins
package color_proc_pkg;

  // full image size, one memory word per pixel
  localparam int img_cols = 160;
  localparam int img_rows = 120;
  localparam int img_pxls = img_cols * img_rows;

  // border removed on each side before counting
  localparam int outframe_cols = 16;
  localparam int outframe_rows = 8;

  // inner frame that feeds the histogram, 128 x 104
  localparam int inframe_cols = img_cols - 2 * outframe_cols;
  localparam int inframe_rows = img_rows - 2 * outframe_rows;

  // column histogram, 8 bins of 16 columns each
  localparam int hist_bins = 8;
  localparam int bin_cols  = inframe_cols / hist_bins;

  // width of one color channel
  localparam int chan_bits = 4;

  // 19200 words need 15 address bits
  typedef logic [14:0] pxl_addr_t;

  // column 0..159 and row 0..119
  typedef logic [7:0] col_t;
  typedef logic [6:0] row_t;

  // bin index 0..7, bin 0 is the leftmost
  typedef logic [2:0] bin_t;

  // one bin holds at most 104 x 16 = 1664
  typedef logic [10:0] hist_val_t;

  // all bins together hold at most 128 x 104 = 13312
  typedef logic [13:0] pxl_count_t;

  typedef logic [chan_bits-1:0] chan_t;

  // red [11:8], green [7:4], blue [3:0]
  typedef logic [3*chan_bits-1:0] pxl_t;

  localparam pxl_t black_pxl = '0;

  // one bit per channel, red is the msb
  typedef enum logic [2:0] {
    mode_none    = 3'b000,
    mode_red     = 3'b100,
    mode_green   = 3'b010,
    mode_blue    = 3'b001,
    mode_yellow  = 3'b110,
    mode_magenta = 3'b101,
    mode_cyan    = 3'b011,
    mode_white   = 3'b111
  } filter_mode_t;

  // no filter out of reset
  localparam filter_mode_t filter_mode_reset = mode_none;

endpackage

// ==== design/color_proc_top.sv ====
// scans one frame at one pixel per clock with no back-pressure; memories are outside this block
`timescale 1ns/1ps

module color_proc_top
  import color_proc_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      new_frame_i,
  input  logic                      proc_ctrl_i,
  input  pxl_t                      orig_pxl_i,
  output pxl_addr_t                 orig_addr_o,
  output logic                      proc_we_o,
  output pxl_addr_t                 proc_addr_o,
  output pxl_t                      proc_pxl_o,
  output logic                      new_frame_proc_o,
  output hist_val_t [0:hist_bins-1] hist_bins_o,
  output pxl_count_t                colorpxls_o,
  output filter_mode_t              filter_mode_o
);

  // tags aligned with orig_pxl_i
  logic         pxl_valid;
  logic         in_frame;
  logic         last_pxl;
  bin_t         bin;
  // classifier result for the current pixel
  logic         pass;
  filter_mode_t filter_mode;

  frame_scanner u_scanner (
    .clk         (clk),
    .rst         (rst),
    .new_frame_i (new_frame_i),
    .orig_addr_o (orig_addr_o),
    .proc_we_o   (proc_we_o),
    .proc_addr_o (proc_addr_o),
    .pxl_valid_o (pxl_valid),
    .in_frame_o  (in_frame),
    .last_pxl_o  (last_pxl),
    .bin_o       (bin)
  );

  filter_mode_select u_mode_select (
    .clk           (clk),
    .rst           (rst),
    .proc_ctrl_i   (proc_ctrl_i),
    .filter_mode_o (filter_mode)
  );

  color_classifier u_classifier (
    .orig_pxl_i    (orig_pxl_i),
    .filter_mode_i (filter_mode),
    .pass_o        (pass),
    .proc_pxl_o    (proc_pxl_o)
  );

  histogram_counter u_histogram (
    .clk              (clk),
    .rst              (rst),
    .pxl_valid_i      (pxl_valid),
    .in_frame_i       (in_frame),
    .pass_i           (pass),
    .last_pxl_i       (last_pxl),
    .bin_i            (bin),
    .hist_bins_o      (hist_bins_o),
    .colorpxls_o      (colorpxls_o),
    .new_frame_proc_o (new_frame_proc_o)
  );

  assign filter_mode_o = filter_mode;

endmodule

// ==== design/filter_mode_select.sv ====
// proc_ctrl_i may be asynchronous and bouncing is not filtered; each clean rise steps the mode
`timescale 1ns/1ps

module filter_mode_select
  import color_proc_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         proc_ctrl_i,
  output filter_mode_t filter_mode_o
);

  logic ctrl_s1;
  logic ctrl_s2;
  logic step;

  // two flop synchronizer
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ctrl_s1 <= 1'b0;
      ctrl_s2 <= 1'b0;
    end else begin
      ctrl_s1 <= proc_ctrl_i;
      ctrl_s2 <= ctrl_s1;
    end
  end

  // one cycle pulse per rise, however long the button is held
  assign step = ctrl_s1 && !ctrl_s2;

  // order: none, red, green, blue, yellow, magenta, cyan, white
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      filter_mode_o <= filter_mode_reset;
    end else if (step) begin
      case (filter_mode_o)
        mode_none:    filter_mode_o <= mode_red;
        mode_red:     filter_mode_o <= mode_green;
        mode_green:   filter_mode_o <= mode_blue;
        mode_blue:    filter_mode_o <= mode_yellow;
        mode_yellow:  filter_mode_o <= mode_magenta;
        mode_magenta: filter_mode_o <= mode_cyan;
        mode_cyan:    filter_mode_o <= mode_white;
        default:      filter_mode_o <= mode_none;
      endcase
    end
  end

endmodule

// ==== design/frame_scanner.sv ====
// needs a memory with exactly one cycle read latency; new_frame_i is ignored while a scan runs
`timescale 1ns/1ps

module frame_scanner
  import color_proc_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      new_frame_i,
  output pxl_addr_t orig_addr_o,
  output logic      proc_we_o,
  output pxl_addr_t proc_addr_o,
  output logic      pxl_valid_o,
  output logic      in_frame_o,
  output logic      last_pxl_o,
  output bin_t      bin_o
);

  logic      scanning;
  pxl_addr_t addr_cnt;
  col_t      col_cnt;
  row_t      row_cnt;
  logic      end_frame;
  logic      end_line;
  // tag stage, lined up with the pixel coming back from memory
  logic      valid_q;
  logic      last_q;
  col_t      col_q;
  row_t      row_q;
  col_t      col_inner;

  assign end_frame = (addr_cnt == pxl_addr_t'(img_pxls - 1));
  assign end_line  = (col_cnt == col_t'(img_cols - 1));

  // idle/scan state plus address, column and row counters
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      scanning <= 1'b0;
      addr_cnt <= '0;
      col_cnt  <= '0;
      row_cnt  <= '0;
    end else if (scanning) begin
      if (end_frame) begin
        // back to idle, counters ready for the next frame
        scanning <= 1'b0;
        addr_cnt <= '0;
        col_cnt  <= '0;
        row_cnt  <= '0;
      end else begin
        addr_cnt <= addr_cnt + 1'b1;
        if (end_line) begin
          col_cnt <= '0;
          row_cnt <= row_cnt + 1'b1;
        end else begin
          col_cnt <= col_cnt + 1'b1;
        end
      end
    end else if (new_frame_i) begin
      scanning <= 1'b1;
    end
  end

  // whole position delayed by the memory latency, not just the column
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
      col_q   <= '0;
      row_q   <= '0;
    end else begin
      valid_q <= scanning;
      last_q  <= scanning && end_frame;
      col_q   <= col_cnt;
      row_q   <= row_cnt;
    end
  end

  // write address trails the read address by one cycle
  always_ff @(posedge clk) begin
    proc_addr_o <= addr_cnt;
  end

  // inner frame is columns 16..143 and rows 8..111
  assign in_frame_o = (col_q >= outframe_cols) && (col_q < outframe_cols + inframe_cols) &&
                      (row_q >= outframe_rows) && (row_q < outframe_rows + inframe_rows);

  // bin only meaningful inside the inner frame
  assign col_inner = col_q - col_t'(outframe_cols);
  assign bin_o     = bin_t'(col_inner / bin_cols);

  assign orig_addr_o = addr_cnt;
  // write strobe and pixel valid share the delayed scan flag
  assign proc_we_o   = valid_q;
  assign pxl_valid_o = valid_q;
  assign last_pxl_o  = last_q;

endmodule

// ==== design/histogram_counter.sv ====
// results only update at frame end; an aborted frame would leave the running counts stale
`timescale 1ns/1ps

module histogram_counter
  import color_proc_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        pxl_valid_i,
  input  logic                        in_frame_i,
  input  logic                        pass_i,
  input  logic                        last_pxl_i,
  input  bin_t                        bin_i,
  output hist_val_t [0:hist_bins-1]   hist_bins_o,
  output pxl_count_t                  colorpxls_o,
  output logic                        new_frame_proc_o
);

  // running counts for the frame in progress
  hist_val_t [0:hist_bins-1] bin_cnt;
  pxl_count_t                total_cnt;

  // counts including the current pixel
  hist_val_t [0:hist_bins-1] bin_next;
  pxl_count_t                total_next;

  logic hit;

  // pixel is counted only when valid, inside the inner frame and passing
  assign hit = pxl_valid_i && in_frame_i && pass_i;

  always_comb begin
    for (int i = 0; i < hist_bins; i++) begin
      // only the addressed bin moves
      bin_next[i] = bin_cnt[i] + hist_val_t'(hit && (bin_i == bin_t'(i)));
    end
    total_next = total_cnt + pxl_count_t'(hit);
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bin_cnt          <= '0;
      total_cnt        <= '0;
      hist_bins_o      <= '0;
      colorpxls_o      <= '0;
      new_frame_proc_o <= 1'b0;
    end else begin
      // done pulse one cycle after the last tag
      new_frame_proc_o <= last_pxl_i;
      if (last_pxl_i) begin
        // hold this frame, the last pixel included
        hist_bins_o <= bin_next;
        colorpxls_o <= total_next;
        // start clean for the next frame
        bin_cnt     <= '0;
        total_cnt   <= '0;
      end else begin
        bin_cnt   <= bin_next;
        total_cnt <= total_next;
      end
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the color processing testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

top=tb_color_proc
build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$top" -f all.f -o "V$top" > "$build_log" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
  cat "$build_log"
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/"V$top" > "$sim_log" 2>&1
status=$?
cat "$sim_log"

if grep -q "STATUS: FAIL" "$sim_log"; then
  echo "simulation reported a failure, see $sim_log"
  exit 1
fi

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

echo "simulation finished without failures"
exit 0

// ==== sim/tb_color_proc.sv ====
// drives a 160x120 frame through behavioral memories; stops at the first mismatch
`timescale 1ns/1ps

module tb_color_proc
  import color_proc_pkg::*;
();

  // one frame from start pulse to done pulse, see scanner and counter latency
  localparam int frame_cycles = img_pxls + 2;
  // six frames plus mode stepping and some slack
  localparam int max_cycles = 200000;

  logic                      clk;
  logic                      rst;
  logic                      new_frame;
  logic                      proc_ctrl;
  pxl_t                      orig_pxl = black_pxl;
  pxl_addr_t                 orig_addr;
  logic                      proc_we;
  pxl_addr_t                 proc_addr;
  pxl_t                      proc_pxl;
  logic                      new_frame_proc;
  hist_val_t [0:hist_bins-1] bin_counts;
  pxl_count_t                colorpxls;
  filter_mode_t              filter_mode;

  // memory models and reference results
  pxl_t   orig_mem [0:img_pxls-1];
  pxl_t   proc_mem [0:img_pxls-1];
  bit     proc_written [0:img_pxls-1];
  int     exp_bins [0:hist_bins-1];
  int     exp_total;
  int     err_cnt = 0;
  int     cycle_cnt = 0;
  integer seed;

  color_proc_top dut (
    .clk              (clk),
    .rst              (rst),
    .new_frame_i      (new_frame),
    .proc_ctrl_i      (proc_ctrl),
    .orig_pxl_i       (orig_pxl),
    .orig_addr_o      (orig_addr),
    .proc_we_o        (proc_we),
    .proc_addr_o      (proc_addr),
    .proc_pxl_o       (proc_pxl),
    .new_frame_proc_o (new_frame_proc),
    .hist_bins_o      (bin_counts),
    .colorpxls_o      (colorpxls),
    .filter_mode_o    (filter_mode)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // original memory reads with one cycle latency
  always @(posedge clk) begin
    orig_pxl <= orig_mem[orig_addr];
  end

  // processed memory captures the write port on we
  always @(posedge clk) begin
    if (proc_we) begin
      proc_mem[proc_addr]     = proc_pxl;
      proc_written[proc_addr] = 1'b1;
    end
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_cnt >= max_cycles);
    $display("simulation ran out of time after %0d cycles", cycle_cnt);
    $display("STATUS: FAIL");
    $fatal(1, "timeout");
  end

  task automatic check_eq(input string name, input int got, input int exp);
    assert (got == exp) else begin
      err_cnt++;
      $display("[ERROR] %0t ns %s: got %0d, expected %0d", $time, name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      err_cnt++;
      $display("%0t ns: %s", $time, what);
      $display("STATUS: FAIL");
      $fatal(1, "%s", what);
    end
  endtask

  task automatic check_word(input int addr, input pxl_t got, input pxl_t exp);
    assert (got == exp) else begin
      err_cnt++;
      $display("[ERROR] %0t ns proc_mem[%0d]: got %03h, expected %03h", $time, addr, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "processed memory mismatch");
    end
  endtask

  // a is at least about twice b, with b minus one wrapping at zero
  function automatic bit ref_dom(input int a, input int b);
    return (a / 2) >= ((b + 15) % 16);
  endfunction

  function automatic bit ref_pass(input pxl_t p, input logic [2:0] mode);
    int r;
    int g;
    int b;
    bit rg;
    bit rb;
    bit gr;
    bit gb;
    bit br;
    bit bg;
    r  = p[11:8];
    g  = p[7:4];
    b  = p[3:0];
    rg = ref_dom(r, g);
    rb = ref_dom(r, b);
    gr = ref_dom(g, r);
    gb = ref_dom(g, b);
    br = ref_dom(b, r);
    bg = ref_dom(b, g);
    case (mode)
      3'b100:  return rg && rb;
      3'b010:  return gr && gb;
      3'b001:  return br && bg;
      3'b110:  return rb && gb && !rg && !gr;
      3'b101:  return rg && bg && !rb && !br;
      3'b011:  return gr && br && !gb && !bg;
      3'b111:  return !rg && !gr && !rb && !br && !gb && !bg && (r > 3);
      default: return 1'b1;
    endcase
  endfunction

  // inner frame is columns 16..143 and rows 8..111, 16 columns per bin
  task automatic compute_expected(input logic [2:0] mode);
    int col;
    int row;
    exp_bins  = '{default: 0};
    exp_total = 0;
    for (int a = 0; a < img_pxls; a++) begin
      col = a % img_cols;
      row = a / img_cols;
      if (col >= 16 && col < 144 && row >= 8 && row < 112 && ref_pass(orig_mem[a], mode)) begin
        exp_bins[(col - 16) / 16]++;
        exp_total++;
      end
    end
  endtask

  task automatic check_counts();
    for (int i = 0; i < hist_bins; i++) begin
      check_eq($sformatf("hist_bins_o[%0d]", i), bin_counts[i], exp_bins[i]);
    end
    check_eq("colorpxls_o", colorpxls, exp_total);
  endtask

  task automatic check_processed(input logic [2:0] mode);
    pxl_t expect_pxl;
    for (int a = 0; a < img_pxls; a++) begin
      expect_pxl = ref_pass(orig_mem[a], mode) ? orig_mem[a] : 12'h000;
      check_true(proc_written[a], "a processed memory word was never written");
      check_word(a, proc_mem[a], expect_pxl);
    end
  endtask

  // start pulse, then wait for the done pulse with a bound
  task automatic run_frame();
    int cycles;
    for (int a = 0; a < img_pxls; a++) proc_written[a] = 1'b0;
    @(negedge clk);
    new_frame = 1'b1;
    cycles = 0;
    do begin
      @(negedge clk);
      new_frame = 1'b0;
      cycles++;
      check_true(cycles <= frame_cycles + 16, "frame done pulse never arrived");
    end while (!new_frame_proc);
  endtask

  // each press is two cycles high, then low long enough to rearm the edge detect
  task automatic select_mode(input logic [2:0] target);
    int presses;
    presses = 0;
    while (filter_mode != target && presses < 8) begin
      @(negedge clk);
      proc_ctrl = 1'b1;
      repeat (2) @(negedge clk);
      proc_ctrl = 1'b0;
      @(negedge clk);
      presses++;
    end
    check_eq("filter_mode_o", filter_mode, target);
  endtask

  task automatic check_reset_state();
    for (int i = 0; i < hist_bins; i++) begin
      check_eq($sformatf("hist_bins_o[%0d]", i), bin_counts[i], 0);
    end
    check_eq("colorpxls_o", colorpxls, 0);
    check_eq("filter_mode_o", filter_mode, 0);
    check_eq("proc_we_o", proc_we, 0);
    check_eq("new_frame_proc_o", new_frame_proc, 0);
  endtask

  // no filter, every word is its own pixel and every inner pixel counts
  task automatic run_unfiltered_frame();
    for (int a = 0; a < img_pxls; a++) begin
      orig_mem[a] = pxl_t'(a ^ (a >> 3) ^ (a >> 12));
    end
    run_frame();
    check_processed(3'b000);
    exp_bins  = '{default: inframe_rows * bin_cols};
    exp_total = inframe_rows * inframe_cols;
    check_counts();
  endtask

  // done pulse delay, addressing, and a start pulse in the middle of the scan
  task automatic check_frame_timing();
    int cycles;
    int pulses;
    @(negedge clk);
    new_frame = 1'b1;
    cycles = 0;
    pulses = 0;
    while (cycles < frame_cycles + 40) begin
      @(negedge clk);
      cycles++;
      new_frame = (cycles == 5000);
      if (cycles <= img_pxls) check_eq("orig_addr_o", orig_addr, cycles - 1);
      check_eq("proc_we_o", proc_we, (cycles >= 2 && cycles <= img_pxls + 1));
      if (proc_we) check_eq("proc_addr_o", proc_addr, cycles - 2);
      if (new_frame_proc) begin
        pulses++;
        check_eq("new_frame_proc_o delay", cycles, frame_cycles);
      end
    end
    check_eq("new_frame_proc_o pulses", pulses, 1);
    check_counts();
  endtask

  task automatic check_mode_stepping();
    logic [2:0] order [0:7];
    order = '{3'b000, 3'b100, 3'b010, 3'b001, 3'b110, 3'b101, 3'b011, 3'b111};
    for (int i = 1; i <= 8; i++) begin
      @(negedge clk);
      proc_ctrl = 1'b1;
      // first edge only loads the synchronizer
      @(negedge clk);
      check_eq("filter_mode_o", filter_mode, order[i - 1]);
      @(negedge clk);
      check_eq("filter_mode_o", filter_mode, order[i % 8]);
      // held longer each round, still one step
      repeat (i) @(negedge clk);
      proc_ctrl = 1'b0;
      repeat (3) @(negedge clk);
      check_eq("filter_mode_o", filter_mode, order[i % 8]);
    end
  endtask

  task automatic run_random_filter_frames();
    logic [2:0] modes [0:2];
    modes = '{3'b100, 3'b110, 3'b111};
    for (int m = 0; m < 3; m++) begin
      select_mode(modes[m]);
      for (int a = 0; a < img_pxls; a++) orig_mem[a] = pxl_t'($random(seed));
      run_frame();
      check_processed(modes[m]);
      compute_expected(modes[m]);
      check_counts();
    end
  endtask

  // red only in bins 2 and 5 plus two border rows that must not count
  task automatic run_crafted_red_frame();
    int col;
    int row;
    for (int a = 0; a < img_pxls; a++) begin
      col = a % img_cols;
      row = a / img_cols;
      if ((row >= 8 && row < 112 && ((col >= 48 && col < 64) || (col >= 96 && col < 112))) ||
          row == 2 || row == 117) begin
        // full red, green and blue at one since a zero channel is never dominated
        orig_mem[a] = 12'hf11;
      end else begin
        orig_mem[a] = (a % 3 == 0) ? 12'h0f0 : ((a % 3 == 1) ? 12'h00f : 12'h444);
      end
    end
    select_mode(3'b100);
    run_frame();
    check_processed(3'b100);
    exp_bins    = '{default: 0};
    exp_bins[2] = 1664;
    exp_bins[5] = 1664;
    exp_total   = 3328;
    check_counts();
  endtask

  initial begin
    rst       = 1'b1;
    new_frame = 1'b0;
    proc_ctrl = 1'b0;
    seed      = 32'hd552194c;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_reset_state();
    run_unfiltered_frame();
    check_frame_timing();
    check_mode_stepping();
    run_random_filter_frames();
    run_crafted_red_frame();
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
